/* design/video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// cen6 strobes from beam sampling to RGB output
`define VIDEO_PXL_DLY 3

// Tile map of 32x32 tiles, 8x8 pixels each
`define VIDEO_MAP_AW 10

// Pattern memory, {tile code, row}, 16-bit words of 8 pixels at 2bpp
`define VIDEO_GFX_AW 11

// Palette of 16 entries, 12-bit RGB
`define VIDEO_PAL_AW 4

// Colour code that lets the layer below show through
`define VIDEO_TRANSPARENT 2'd3

// CPU address map
`define VIDEO_CPU_CHAR_BASE 12'h000
`define VIDEO_CPU_SCR_BASE  12'h400
`define VIDEO_CPU_REG_BASE  12'h800

`endif

/* design/video_pkg.sv */
package video_pkg;

    // Target memory of the programming port
    typedef enum logic [1:0] {
        prog_char_gfx = 2'd0,
        prog_scr_gfx  = 2'd1,
        prog_palette  = 2'd2
    } prog_region_e;

    // Layer picked by the colour mixer
    typedef enum logic [1:0] {
        layer_char = 2'd0,
        layer_scr  = 2'd1,
        // Background uses palette entry 0
        layer_back = 2'd2
    } layer_e;

endpackage

/* design/video_bus_port.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_bus_port (
    input  logic                        clk,
    input  logic                        rst_n,
    // CPU bus, write only
    input  logic [11:0]                 cpu_addr,
    input  logic [7:0]                  cpu_dout,
    input  logic                        cpu_we,
    // Programming port
    input  video_pkg::prog_region_e     prog_sel,
    input  logic                        prog_we,
    // Tile map writes
    output logic                        char_map_we,
    output logic                        scr_map_we,
    output logic [`VIDEO_MAP_AW-1:0]    map_addr,
    output logic [7:0]                  map_din,
    // Pattern and palette strobes
    output logic                        char_gfx_we,
    output logic                        scr_gfx_we,
    output logic                        pal_we,
    // Scroll and layer enable registers
    output logic [7:0]                  scr_hpos,
    output logic [7:0]                  scr_vpos,
    output logic                        char_on,
    output logic                        scr_on
);

    localparam logic [11:0] CHAR_BASE = `VIDEO_CPU_CHAR_BASE;
    localparam logic [11:0] SCR_BASE  = `VIDEO_CPU_SCR_BASE;
    localparam logic [11:0] REG_HPOS  = `VIDEO_CPU_REG_BASE;
    localparam logic [11:0] REG_VPOS  = `VIDEO_CPU_REG_BASE + 12'd1;
    localparam logic [11:0] REG_ENA   = `VIDEO_CPU_REG_BASE + 12'd2;

    // Map regions are picked by the bits above the map address
    assign char_map_we = cpu_we &&
        (cpu_addr[11:`VIDEO_MAP_AW] == CHAR_BASE[11:`VIDEO_MAP_AW]);
    assign scr_map_we  = cpu_we &&
        (cpu_addr[11:`VIDEO_MAP_AW] == SCR_BASE[11:`VIDEO_MAP_AW]);
    assign map_addr    = cpu_addr[`VIDEO_MAP_AW-1:0];
    assign map_din     = cpu_dout;

    // One strobe per programming target
    assign char_gfx_we = prog_we && (prog_sel == video_pkg::prog_char_gfx);
    assign scr_gfx_we  = prog_we && (prog_sel == video_pkg::prog_scr_gfx);
    assign pal_we      = prog_we && (prog_sel == video_pkg::prog_palette);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scr_hpos <= 8'd0;
            scr_vpos <= 8'd0;
            // Both layers visible out of reset
            char_on  <= 1'b1;
            scr_on   <= 1'b1;
        end else if (cpu_we) begin
            case (cpu_addr)
                REG_HPOS: scr_hpos <= cpu_dout;
                REG_VPOS: scr_vpos <= cpu_dout;
                REG_ENA: begin
                    char_on <= cpu_dout[0];
                    scr_on  <= cpu_dout[1];
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/video_char.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_char (
    input  logic                        clk,
    input  logic                        cen6,
    // Beam position
    input  logic [7:0]                  H,
    input  logic [7:0]                  V,
    // Tile map, CPU side
    input  logic                        map_we,
    input  logic [`VIDEO_MAP_AW-1:0]    map_addr,
    input  logic [7:0]                  map_din,
    // Pattern memory load
    input  logic                        gfx_we,
    input  logic [`VIDEO_GFX_AW-1:0]    gfx_addr,
    input  logic [15:0]                 gfx_din,
    input  logic                        layer_on,
    output logic [1:0]                  char_pxl
);

    logic [7:0]                 map_ram [0:(1 << `VIDEO_MAP_AW)-1];
    logic [15:0]                gfx_ram [0:(1 << `VIDEO_GFX_AW)-1];

    logic [`VIDEO_MAP_AW-1:0]   map_rd_addr;
    logic [`VIDEO_GFX_AW-1:0]   gfx_rd_addr;

    // Stage 1 registers
    logic [7:0]                 tile_code;
    logic [2:0]                 row_s1;
    logic [2:0]                 col_s1;

    // Stage 2 registers
    logic [15:0]                gfx_word;
    logic [2:0]                 col_s2;

    logic [15:0]                pxl_shift;

    // Tile map and pattern writes
    always_ff @(posedge clk) begin
        if (map_we) begin
            map_ram[map_addr] <= map_din;
        end
    end

    always_ff @(posedge clk) begin
        if (gfx_we) begin
            gfx_ram[gfx_addr] <= gfx_din;
        end
    end

    // Tile row in the top bits, tile column below
    assign map_rd_addr = {V[7:3], H[7:3]};

    // Stage 1: map read, keep fine row and column
    always_ff @(posedge clk) begin
        if (cen6) begin
            tile_code <= map_ram[map_rd_addr];
            row_s1    <= V[2:0];
            col_s1    <= H[2:0];
        end
    end

    assign gfx_rd_addr = {tile_code, row_s1};

    // Stage 2: pattern read
    always_ff @(posedge clk) begin
        if (cen6) begin
            gfx_word <= gfx_ram[gfx_rd_addr];
            col_s2   <= col_s1;
        end
    end

    // Leftmost pixel sits in the top two bits
    assign pxl_shift = gfx_word << {col_s2, 1'b0};

    // Disabled layer is see-through
    assign char_pxl = layer_on ? pxl_shift[15:14] : `VIDEO_TRANSPARENT;

endmodule

/* design/video_scroll.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_scroll (
    input  logic                        clk,
    input  logic                        cen6,
    // Beam position
    input  logic [7:0]                  H,
    input  logic [7:0]                  V,
    // Scroll offsets
    input  logic [7:0]                  hpos,
    input  logic [7:0]                  vpos,
    // Tile map, CPU side
    input  logic                        map_we,
    input  logic [`VIDEO_MAP_AW-1:0]    map_addr,
    input  logic [7:0]                  map_din,
    // Pattern memory load
    input  logic                        gfx_we,
    input  logic [`VIDEO_GFX_AW-1:0]    gfx_addr,
    input  logic [15:0]                 gfx_din,
    input  logic                        layer_on,
    output logic [1:0]                  scr_pxl
);

    logic [7:0]                 map_ram [0:(1 << `VIDEO_MAP_AW)-1];
    logic [15:0]                gfx_ram [0:(1 << `VIDEO_GFX_AW)-1];

    // Position in the scrolled plane, wraps at 256
    logic [7:0]                 scr_h;
    logic [7:0]                 scr_v;

    logic [`VIDEO_MAP_AW-1:0]   map_rd_addr;
    logic [`VIDEO_GFX_AW-1:0]   gfx_rd_addr;

    // Stage 1 registers
    logic [7:0]                 tile_code;
    logic [2:0]                 row_s1;
    logic [2:0]                 col_s1;

    // Stage 2 registers
    logic [15:0]                gfx_word;
    logic [2:0]                 col_s2;

    logic [15:0]                pxl_shift;

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_ram[map_addr] <= map_din;
        end
    end

    always_ff @(posedge clk) begin
        if (gfx_we) begin
            gfx_ram[gfx_addr] <= gfx_din;
        end
    end

    assign scr_h = H + hpos;
    assign scr_v = V + vpos;

    assign map_rd_addr = {scr_v[7:3], scr_h[7:3]};

    // Stage 1: map read at the scrolled tile
    always_ff @(posedge clk) begin
        if (cen6) begin
            tile_code <= map_ram[map_rd_addr];
            row_s1    <= scr_v[2:0];
            col_s1    <= scr_h[2:0];
        end
    end

    assign gfx_rd_addr = {tile_code, row_s1};

    // Stage 2: pattern read
    always_ff @(posedge clk) begin
        if (cen6) begin
            gfx_word <= gfx_ram[gfx_rd_addr];
            col_s2   <= col_s1;
        end
    end

    assign pxl_shift = gfx_word << {col_s2, 1'b0};

    // Code 0 when off, the mixer drops to the background then
    assign scr_pxl = layer_on ? pxl_shift[15:14] : 2'd0;

endmodule

/* design/video_colmix.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_colmix (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen6,
    // Blanking, active high in the visible area
    input  logic                        LHBL,
    input  logic                        LVBL,
    // Layer codes, already two stages late
    input  logic [1:0]                  char_pxl,
    input  logic [1:0]                  scr_pxl,
    input  logic                        scr_on,
    // Palette load
    input  logic                        pal_we,
    input  logic [`VIDEO_PAL_AW-1:0]    pal_addr,
    input  logic [11:0]                 pal_din,
    // Video out
    output logic [3:0]                  red,
    output logic [3:0]                  green,
    output logic [3:0]                  blue,
    output logic                        LHBL_dly,
    output logic                        LVBL_dly
);

    localparam int BLANK_MSB = `VIDEO_PXL_DLY - 2;

    logic [11:0]                pal_ram [0:(1 << `VIDEO_PAL_AW)-1];

    // Blank shift registers matching the layer pipeline
    logic [BLANK_MSB:0]         hb_sr;
    logic [BLANK_MSB:0]         vb_sr;

    video_pkg::layer_e          layer;
    logic [`VIDEO_PAL_AW-1:0]   pal_idx;
    logic                       active;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_din;
        end
    end

    // Priority: characters, then scroll, then background
    always_comb begin
        if (char_pxl != `VIDEO_TRANSPARENT) begin
            layer = video_pkg::layer_char;
        end else if (scr_on) begin
            layer = video_pkg::layer_scr;
        end else begin
            layer = video_pkg::layer_back;
        end
    end

    // Characters use entries 4-7, scroll 8-11
    always_comb begin
        case (layer)
            video_pkg::layer_char: pal_idx = {2'b01, char_pxl};
            video_pkg::layer_scr:  pal_idx = {2'b10, scr_pxl};
            default:               pal_idx = '0;
        endcase
    end

    assign active = hb_sr[BLANK_MSB] & vb_sr[BLANK_MSB];

    // Stage 3: palette lookup and blanking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb_sr    <= '0;
            vb_sr    <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= 4'd0;
            green    <= 4'd0;
            blue     <= 4'd0;
        end else if (cen6) begin
            hb_sr    <= {hb_sr[BLANK_MSB-1:0], LHBL};
            vb_sr    <= {vb_sr[BLANK_MSB-1:0], LVBL};
            LHBL_dly <= hb_sr[BLANK_MSB];
            LVBL_dly <= vb_sr[BLANK_MSB];
            if (active) begin
                {red, green, blue} <= pal_ram[pal_idx];
            end else begin
                {red, green, blue} <= 12'd0;
            end
        end
    end

endmodule

/* design/video_top.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen6,
    // CPU bus
    input  logic [11:0]                 cpu_addr,
    input  logic [7:0]                  cpu_dout,
    input  logic                        cpu_we,
    // Programming port
    input  video_pkg::prog_region_e     prog_sel,
    input  logic [`VIDEO_GFX_AW-1:0]    prog_addr,
    input  logic [15:0]                 prog_din,
    input  logic                        prog_we,
    // Beam
    input  logic [7:0]                  H,
    input  logic [7:0]                  V,
    input  logic                        LHBL,
    input  logic                        LVBL,
    // Video out
    output logic [3:0]                  red,
    output logic [3:0]                  green,
    output logic [3:0]                  blue,
    output logic                        LHBL_dly,
    output logic                        LVBL_dly
);

    logic                       char_map_we;
    logic                       scr_map_we;
    logic [`VIDEO_MAP_AW-1:0]   map_addr;
    logic [7:0]                 map_din;
    logic                       char_gfx_we;
    logic                       scr_gfx_we;
    logic                       pal_we;
    logic [7:0]                 scr_hpos;
    logic [7:0]                 scr_vpos;
    logic                       char_on;
    logic                       scr_on;
    logic [1:0]                 char_pxl;
    logic [1:0]                 scr_pxl;

    video_bus_port u_bus (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .cpu_addr    ( cpu_addr     ),
        .cpu_dout    ( cpu_dout     ),
        .cpu_we      ( cpu_we       ),
        .prog_sel    ( prog_sel     ),
        .prog_we     ( prog_we      ),
        .char_map_we ( char_map_we  ),
        .scr_map_we  ( scr_map_we   ),
        .map_addr    ( map_addr     ),
        .map_din     ( map_din      ),
        .char_gfx_we ( char_gfx_we  ),
        .scr_gfx_we  ( scr_gfx_we   ),
        .pal_we      ( pal_we       ),
        .scr_hpos    ( scr_hpos     ),
        .scr_vpos    ( scr_vpos     ),
        .char_on     ( char_on      ),
        .scr_on      ( scr_on       )
    );

    video_char u_char (
        .clk         ( clk          ),
        .cen6        ( cen6         ),
        .H           ( H            ),
        .V           ( V            ),
        .map_we      ( char_map_we  ),
        .map_addr    ( map_addr     ),
        .map_din     ( map_din      ),
        .gfx_we      ( char_gfx_we  ),
        .gfx_addr    ( prog_addr    ),
        .gfx_din     ( prog_din     ),
        .layer_on    ( char_on      ),
        .char_pxl    ( char_pxl     )
    );

    video_scroll u_scroll (
        .clk         ( clk          ),
        .cen6        ( cen6         ),
        .H           ( H            ),
        .V           ( V            ),
        .hpos        ( scr_hpos     ),
        .vpos        ( scr_vpos     ),
        .map_we      ( scr_map_we   ),
        .map_addr    ( map_addr     ),
        .map_din     ( map_din      ),
        .gfx_we      ( scr_gfx_we   ),
        .gfx_addr    ( prog_addr    ),
        .gfx_din     ( prog_din     ),
        .layer_on    ( scr_on       ),
        .scr_pxl     ( scr_pxl      )
    );

    // Palette takes the low bits of the programming bus
    video_colmix u_colmix (
        .clk         ( clk                          ),
        .rst_n       ( rst_n                        ),
        .cen6        ( cen6                         ),
        .LHBL        ( LHBL                         ),
        .LVBL        ( LVBL                         ),
        .char_pxl    ( char_pxl                     ),
        .scr_pxl     ( scr_pxl                      ),
        .scr_on      ( scr_on                       ),
        .pal_we      ( pal_we                       ),
        .pal_addr    ( prog_addr[`VIDEO_PAL_AW-1:0] ),
        .pal_din     ( prog_din[11:0]               ),
        .red         ( red                          ),
        .green       ( green                        ),
        .blue        ( blue                         ),
        .LHBL_dly    ( LHBL_dly                     ),
        .LVBL_dly    ( LVBL_dly                     )
    );

endmodule

/* test/video_tb.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_tb;

    localparam int PXL_DLY      = `VIDEO_PXL_DLY;
    localparam int MAP_WORDS    = 1 << `VIDEO_MAP_AW;
    localparam int GFX_WORDS    = 1 << `VIDEO_GFX_AW;
    localparam int PAL_WORDS    = 1 << `VIDEO_PAL_AW;
    localparam int CHAR_LINES   = 32;
    localparam int SCROLL_LINES = 16;
    localparam int ENABLE_LINES = 8;
    localparam int BLANK_LINES  = 16;
    localparam int LIVE_LINES   = 8;
    localparam int SCAN_LINES   = CHAR_LINES + SCROLL_LINES + 2 * ENABLE_LINES
                                  + BLANK_LINES + LIVE_LINES;
    // Two clocks per write and per pixel
    localparam int LOAD_CYCLES  = 2 * (2 * MAP_WORDS + 2 * GFX_WORDS + PAL_WORDS + 8);
    localparam int SCAN_CYCLES  = 2 * (256 * SCAN_LINES + 6 * (PXL_DLY - 1));
    localparam int MAX_CYCLES   = 2 * (LOAD_CYCLES + SCAN_CYCLES + 5);

    logic                       clk;
    logic                       rst_n;
    logic                       cen6;
    logic [11:0]                cpu_addr;
    logic [7:0]                 cpu_dout;
    logic                       cpu_we;
    video_pkg::prog_region_e    prog_sel;
    logic [`VIDEO_GFX_AW-1:0]   prog_addr;
    logic [15:0]                prog_din;
    logic                       prog_we;
    logic [7:0]                 H;
    logic [7:0]                 V;
    logic                       LHBL;
    logic                       LVBL;
    logic [3:0]                 red;
    logic [3:0]                 green;
    logic [3:0]                 blue;
    logic                       LHBL_dly;
    logic                       LVBL_dly;

    // Mirrors of every DUT memory and register
    logic [7:0]                 char_map_m [0:MAP_WORDS-1];
    logic [7:0]                 scr_map_m  [0:MAP_WORDS-1];
    logic [15:0]                char_gfx_m [0:GFX_WORDS-1];
    logic [15:0]                scr_gfx_m  [0:GFX_WORDS-1];
    logic [11:0]                pal_m      [0:PAL_WORDS-1];
    logic [7:0]                 hpos_m;
    logic [7:0]                 vpos_m;
    logic                       char_on_m;
    logic                       scr_on_m;

    // Expected {LHBL_dly, LVBL_dly, rgb} per strobe
    logic [13:0]                exp_q [$];
    string                      name_q [$];
    logic [13:0]                exp_word;
    string                      exp_name;
    logic                       strobe_d;
    logic [31:0]                lfsr_state;
    logic [15:0]                rnd;
    int                         cycle_cnt = 0;

    video_top i_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .cpu_we   ( cpu_we   ),
        .prog_sel ( prog_sel ),
        .prog_addr( prog_addr),
        .prog_din ( prog_din ),
        .prog_we  ( prog_we  ),
        .H        ( H        ),
        .V        ( V        ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

    always #2 clk = ~clk;

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    // Leftmost pixel in the top two bits
    function automatic logic [1:0] pick_pixel(input logic [15:0] word, input int col);
        logic [15:0] tmp;
        tmp = word >> (14 - 2 * col);
        pick_pixel = tmp[1:0];
    endfunction

    function automatic logic [13:0] ref_pixel(input logic [7:0] h, input logic [7:0] v,
                                              input logic hb, input logic vb);
        logic [7:0]  sh;
        logic [7:0]  sv;
        logic [1:0]  cpx;
        logic [1:0]  spx;
        logic [3:0]  idx;
        logic [11:0] rgb;
        cpx = pick_pixel(char_gfx_m[{char_map_m[{v[7:3], h[7:3]}], v[2:0]}], int'(h[2:0]));
        if (!char_on_m) begin
            cpx = 2'd3;
        end
        sh  = h + hpos_m;
        sv  = v + vpos_m;
        spx = pick_pixel(scr_gfx_m[{scr_map_m[{sv[7:3], sh[7:3]}], sv[2:0]}], int'(sh[2:0]));
        if (!scr_on_m) begin
            spx = 2'd0;
        end
        // Characters over scroll over background
        if (cpx != 2'd3) begin
            idx = 4'd4 + {2'b00, cpx};
        end else if (scr_on_m) begin
            idx = 4'd8 + {2'b00, spx};
        end else begin
            idx = 4'd0;
        end
        rgb = (hb && vb) ? pal_m[idx] : 12'd0;
        ref_pixel = {hb, vb, rgb};
    endfunction

    task automatic check(input string name, input logic [13:0] expected,
                         input logic [13:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic cpu_write(input logic [11:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        if (addr < `VIDEO_CPU_SCR_BASE) begin
            char_map_m[addr[9:0]] = data;
        end else if (addr < `VIDEO_CPU_REG_BASE) begin
            scr_map_m[addr[9:0]] = data;
        end else if (addr == `VIDEO_CPU_REG_BASE) begin
            hpos_m = data;
        end else if (addr == `VIDEO_CPU_REG_BASE + 12'd1) begin
            vpos_m = data;
        end else if (addr == `VIDEO_CPU_REG_BASE + 12'd2) begin
            {scr_on_m, char_on_m} = data[1:0];
        end
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    task automatic prog_write(input video_pkg::prog_region_e sel,
                              input logic [10:0] addr, input logic [15:0] data);
        @(posedge clk);
        #1;
        prog_sel  = sel;
        prog_addr = addr;
        prog_din  = data;
        prog_we   = 1'b1;
        case (sel)
            video_pkg::prog_char_gfx: char_gfx_m[addr] = data;
            video_pkg::prog_scr_gfx:  scr_gfx_m[addr]  = data;
            default:                  pal_m[addr[3:0]] = data[11:0];
        endcase
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic load_memories();
        logic [15:0] r;
        for (int i = 0; i < MAP_WORDS; i++) begin
            take_bits(8, r);
            cpu_write(`VIDEO_CPU_CHAR_BASE + 12'(i), r[7:0]);
            take_bits(8, r);
            cpu_write(`VIDEO_CPU_SCR_BASE + 12'(i), r[7:0]);
        end
        for (int i = 0; i < GFX_WORDS; i++) begin
            take_bits(16, r);
            prog_write(video_pkg::prog_char_gfx, 11'(i), r);
            take_bits(16, r);
            prog_write(video_pkg::prog_scr_gfx, 11'(i), r);
        end
        // Upper bits of the palette data are don't-care
        for (int i = 0; i < PAL_WORDS; i++) begin
            take_bits(16, r);
            prog_write(video_pkg::prog_palette, 11'(i), r);
        end
    endtask

    // One pixel per cen6 strobe with a strobe every other clock
    task automatic drive_pixel(input string name, input logic [7:0] h, input logic [7:0] v,
                               input logic hb, input logic vb);
        @(posedge clk);
        #1;
        H    = h;
        V    = v;
        LHBL = hb;
        LVBL = vb;
        cen6 = 1'b1;
        exp_q.push_back(ref_pixel(h, v, hb, vb));
        name_q.push_back(name);
        @(posedge clk);
        #1;
        cen6 = 1'b0;
    endtask

    task automatic scan_lines(input string name, input logic [7:0] v0, input int lines,
                              input logic rand_blank);
        logic [15:0] r;
        logic        hb;
        logic        vb;
        for (int l = 0; l < lines; l++) begin
            for (int h = 0; h < 256; h++) begin
                hb = 1'b1;
                vb = 1'b1;
                if (rand_blank) begin
                    take_bits(4, r);
                    hb = |r[1:0];
                    vb = |r[3:2];
                end
                drive_pixel(name, 8'(h), v0 + 8'(l), hb, vb);
            end
        end
        // Blanked pixels push the last real ones out
        for (int f = 0; f < PXL_DLY - 1; f++) begin
            drive_pixel(name, 8'd0, 8'd0, 1'b0, 1'b0);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_d <= 1'b0;
        end else begin
            strobe_d <= cen6;
        end
    end

    // Compare after each strobe once outputs settle at the falling edge
    always @(negedge clk) begin
        if (strobe_d && exp_q.size() >= PXL_DLY) begin
            exp_word = exp_q.pop_front();
            exp_name = name_q.pop_front();
            check(exp_name, exp_word, {LHBL_dly, LVBL_dly, red, green, blue});
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cen6       = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        cpu_we     = 1'b0;
        prog_sel   = video_pkg::prog_char_gfx;
        prog_addr  = '0;
        prog_din   = '0;
        prog_we    = 1'b0;
        H          = '0;
        V          = '0;
        LHBL       = 1'b0;
        LVBL       = 1'b0;
        hpos_m     = 8'd0;
        vpos_m     = 8'd0;
        char_on_m  = 1'b1;
        scr_on_m   = 1'b1;
        lfsr_state = 32'hb09b;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check("reset_values", 14'd0, {LHBL_dly, LVBL_dly, red, green, blue});

        // Reset pipeline drains as zeros
        for (int i = 0; i < PXL_DLY - 1; i++) begin
            exp_q.push_back(14'd0);
            name_q.push_back("reset_pipeline");
        end

        load_memories();
        scan_lines("char_layer", 8'd0, CHAR_LINES, 1'b0);

        take_bits(16, rnd);
        cpu_write(`VIDEO_CPU_REG_BASE, rnd[7:0]);
        cpu_write(`VIDEO_CPU_REG_BASE + 12'd1, rnd[15:8]);
        take_bits(8, rnd);
        scan_lines("scroll_offsets", rnd[7:0], SCROLL_LINES, 1'b0);

        cpu_write(`VIDEO_CPU_REG_BASE + 12'd2, 8'h02);
        scan_lines("char_off", 8'd40, ENABLE_LINES, 1'b0);
        cpu_write(`VIDEO_CPU_REG_BASE + 12'd2, 8'h00);
        scan_lines("both_off", 8'd96, ENABLE_LINES, 1'b0);

        cpu_write(`VIDEO_CPU_REG_BASE + 12'd2, 8'h03);
        scan_lines("blanking", 8'd128, BLANK_LINES, 1'b1);

        // One shown palette entry in 4 to 11 and one tile in row 0
        take_bits(15, rnd);
        prog_write(video_pkg::prog_palette, 11'd4 + {8'd0, rnd[2:0]}, {4'd0, rnd[14:3]});
        take_bits(13, rnd);
        cpu_write(`VIDEO_CPU_CHAR_BASE + {7'd0, rnd[4:0]}, rnd[12:5]);
        scan_lines("live_writes", 8'd0, LIVE_LINES, 1'b0);

        repeat (2) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/video_pkg.sv
design/video_bus_port.sv
design/video_char.sv
design/video_scroll.sv
design/video_colmix.sv
design/video_top.sv
test/video_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the video subsystem testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing -f verilog.f --top-module video_tb -o video_sim \
    && ./obj_dir/video_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "All checks passed" sim.log 2>/dev/null && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
